// File: src/swj_cfg.svh
`ifndef SWJ_CFG_SVH
`define SWJ_CFG_SVH

// register bus
`define SWJ_ADDR_W      12
`define SWJ_CR_OFS      12'h000
`define SWJ_CLKDIV_OFS  12'h004

// response ram
`define SWJ_RAM_AW      10

// command payload
`define SWJ_PAYLOAD_W   64
`define SWJ_PINS_BITS   48  // value, select, 4 wait bytes

// bit positions in start/done
`define SWJ_CMD_SEQ     0
`define SWJ_CMD_PINS    1
`define SWJ_CMD_N       2

`endif

// File: src/swj_pkg.sv
`include "swj_cfg.svh"

package swj_pkg;

    typedef logic [7:0]                  byte_t;
    typedef logic [31:0]                 word_t;
    typedef logic [`SWJ_PAYLOAD_W-1:0]   payload_t;
    typedef logic [6:0]                  bitlen_t;   // 1..64
    typedef logic [8:0]                  seqlen_t;   // up to 256
    typedef logic [`SWJ_RAM_AW-1:0]      ram_addr_t;
    typedef logic [15:0]                 clkdiv_t;
    typedef logic [`SWJ_CMD_N-1:0]       cmd_vec_t;

    typedef enum logic {
        OP_SEQ,
        OP_PINS
    } drv_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_ISSUE,
        ST_WAIT,
        ST_REPLY,
        ST_DONE
    } cmd_state_t;

    typedef struct packed {
        logic                   write_en;
        logic                   read_en;
        logic [`SWJ_ADDR_W-1:0] addr;
        word_t                  wdata;
        logic [3:0]             byte_strobe;
    } reg_bus_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

    typedef struct packed {
        logic     valid;
        drv_op_t  op;
        bitlen_t  len;
        payload_t data;
    } drv_req_t;

    typedef struct packed {
        logic swdio;
        logic tdo;
        logic trst_n;
        logic srst_n;
    } pin_in_t;

endpackage

// File: src/swj_reg_bank.sv
`timescale 1ns/1ps
`include "swj_cfg.svh"

module swj_reg_bank
    import swj_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  reg_bus_t bus,
    output word_t    rdata,
    output logic     swd_mode,
    output clkdiv_t  clkdiv
);

    localparam logic [`SWJ_ADDR_W-1:0] cr_ofs     = `SWJ_CR_OFS;
    localparam logic [`SWJ_ADDR_W-1:0] clkdiv_ofs = `SWJ_CLKDIV_OFS;

    word_t cr_q;
    word_t clkdiv_q;
    logic  hit_cr;
    logic  hit_div;

    function automatic word_t strobe_merge(input word_t old, input word_t wdata,
                                           input logic [3:0] strb);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[i*8 +: 8] = wdata[i*8 +: 8];
        end
        return res;
    endfunction

    // word decode, byte offset bits ignored
    assign hit_cr  = bus.addr[`SWJ_ADDR_W-1:2] == cr_ofs[`SWJ_ADDR_W-1:2];
    assign hit_div = bus.addr[`SWJ_ADDR_W-1:2] == clkdiv_ofs[`SWJ_ADDR_W-1:2];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cr_q     <= '0;
            clkdiv_q <= '0;
        end else if (bus.write_en) begin
            if (hit_cr)
                cr_q <= strobe_merge(cr_q, bus.wdata, bus.byte_strobe);
            if (hit_div)
                clkdiv_q <= strobe_merge(clkdiv_q, bus.wdata, bus.byte_strobe);
        end
    end

    always_comb begin
        rdata = '0;
        if (bus.read_en && hit_cr)
            rdata = cr_q;
        else if (bus.read_en && hit_div)
            rdata = clkdiv_q;
    end

    assign swd_mode = cr_q[0];
    assign clkdiv   = clkdiv_q[15:0];

endmodule

// File: src/swj_clk_timer.sv
`timescale 1ns/1ps

module swj_clk_timer
    import swj_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    run,
    input  clkdiv_t clkdiv,
    output logic    tick
);

    clkdiv_t cnt_q;

    // one tick every clkdiv+1 cycles
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cnt_q <= '0;
        end else if (!run) begin
            cnt_q <= clkdiv;  // restart on every new run
        end else if (cnt_q == '0) begin
            cnt_q <= clkdiv;
        end else begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign tick = run && (cnt_q == '0);

endmodule

// File: src/swj_byte_collector.sv
`timescale 1ns/1ps

module swj_byte_collector
    import swj_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  bitlen_t  bits,
    input  logic     in_valid,
    input  byte_t    in_data,
    output logic     in_ready,
    output logic     done,
    output payload_t data
);

    logic [3:0] need;
    logic [3:0] cnt_q;
    logic [3:0] idx;
    logic       busy_q;
    logic       accept;

    assign need     = 4'((8'(bits) + 8'd7) >> 3);  // bytes to gather
    assign idx      = start ? 4'd0 : cnt_q;
    assign in_ready = start || busy_q;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
            cnt_q  <= '0;
        end else begin
            if (start) begin
                busy_q <= 1'b1;
                done   <= 1'b0;
                cnt_q  <= '0;
            end
            if (accept) begin
                cnt_q <= idx + 4'd1;
                if (idx + 4'd1 >= need) begin  // last byte
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // unused upper bytes read as zero
    always_ff @(posedge clk) begin
        if (start)
            data <= '0;
        if (accept)
            data[{idx[2:0], 3'b000} +: 8] <= in_data;
    end

endmodule

// File: src/swj_pin_driver.sv
`timescale 1ns/1ps

module swj_pin_driver
    import swj_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  drv_req_t req,
    input  logic     tick,
    output logic     timer_run,
    output logic     busy,
    output logic     ack,
    output byte_t    rdata,
    input  pin_in_t  pins_in,
    output logic     swclk_o,
    output logic     swdio_o,
    output logic     swdio_oe,
    output logic     tdi_o,
    output logic     trst_o,
    output logic     srst_o
);

    payload_t   shift_q;
    bitlen_t    remain_q;
    logic       seq_q;
    logic       high_q;     // next tick raises swclk
    logic [1:0] pin_cnt_q;
    logic       seq_tick;

    assign seq_tick  = seq_q && tick;
    assign timer_run = seq_q;
    assign swdio_oe  = seq_q;
    assign busy      = seq_q || (pin_cnt_q != 2'd0);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            seq_q     <= 1'b0;
            high_q    <= 1'b0;
            remain_q  <= '0;
            pin_cnt_q <= '0;
            ack       <= 1'b0;
            swclk_o   <= 1'b0;
            swdio_o   <= 1'b0;
            tdi_o     <= 1'b0;
            trst_o    <= 1'b1;
            srst_o    <= 1'b1;
        end else begin
            ack <= 1'b0;
            if (req.valid && req.op == OP_SEQ) begin
                seq_q    <= 1'b1;
                high_q   <= 1'b0;
                remain_q <= req.len;
            end else if (req.valid) begin
                // byte 0 value, byte 1 select
                if (req.data[8])  swclk_o <= req.data[0];
                if (req.data[9])  swdio_o <= req.data[1];
                if (req.data[10]) tdi_o   <= req.data[2];
                if (req.data[13]) trst_o  <= req.data[5];
                if (req.data[15]) srst_o  <= req.data[7];
                pin_cnt_q <= 2'd1;
            end else if (seq_tick) begin
                if (high_q) begin
                    swclk_o  <= 1'b1;
                    remain_q <= remain_q - 1'b1;
                    high_q   <= 1'b0;
                end else begin
                    swclk_o <= 1'b0;
                    if (remain_q == '0) begin  // final low phase
                        seq_q <= 1'b0;
                        ack   <= 1'b1;
                    end else begin
                        swdio_o <= shift_q[0];
                        high_q  <= 1'b1;
                    end
                end
            end
            if (pin_cnt_q == 2'd2) begin
                ack       <= 1'b1;
                pin_cnt_q <= 2'd0;
            end else if (pin_cnt_q != 2'd0) begin
                pin_cnt_q <= pin_cnt_q + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.op == OP_SEQ)
            shift_q <= req.data;
        else if (seq_tick && high_q)
            shift_q <= shift_q >> 1;  // lsb first
        if (pin_cnt_q == 2'd2)
            rdata <= {pins_in.srst_n, 1'b0, pins_in.trst_n, 1'b0,
                      pins_in.tdo, tdi_o, pins_in.swdio, swclk_o};
    end

endmodule

// File: src/swj_cmd_fsm.sv
`timescale 1ns/1ps
`include "swj_cfg.svh"

module swj_cmd_fsm
    import swj_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  cmd_vec_t  start,
    output cmd_vec_t  done,
    input  logic      in_valid,
    input  byte_t     in_data,
    output logic      col_start,
    output bitlen_t   col_bits,
    input  logic      col_done,
    input  payload_t  col_data,
    output drv_req_t  drv_req,
    input  logic      drv_ack,
    input  byte_t     drv_rdata,
    output ram_wr_t   ram_wr,
    output ram_addr_t packet_len
);

    cmd_state_t state;
    drv_op_t    op_q;
    seqlen_t    remain_q;   // sequence bits still to collect
    seqlen_t    first_len;

    function automatic bitlen_t chunk(input seqlen_t n);
        return (n > seqlen_t'(64)) ? bitlen_t'(64) : bitlen_t'(n);
    endfunction

    assign first_len = (in_data == 8'd0) ? seqlen_t'(256) : seqlen_t'(in_data);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            op_q       <= OP_SEQ;
            remain_q   <= '0;
            col_start  <= 1'b0;
            col_bits   <= '0;
            drv_req    <= '0;
            ram_wr     <= '0;
            packet_len <= '0;
            done       <= '0;
        end else begin
            col_start     <= 1'b0;
            drv_req.valid <= 1'b0;
            ram_wr.en     <= 1'b0;
            if (start == '0) begin
                state    <= ST_IDLE;
                done     <= '0;
                col_bits <= '0;  // zero marks idle for the top
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (start[`SWJ_CMD_SEQ]) begin
                            if (in_valid) begin  // length byte
                                op_q      <= OP_SEQ;
                                remain_q  <= first_len;
                                col_bits  <= chunk(first_len);
                                col_start <= 1'b1;
                                state     <= ST_COLLECT;
                            end
                        end else if (start[`SWJ_CMD_PINS]) begin
                            op_q      <= OP_PINS;
                            col_bits  <= bitlen_t'(`SWJ_PINS_BITS);
                            col_start <= 1'b1;
                            state     <= ST_COLLECT;
                        end
                    end
                    ST_COLLECT: begin
                        // done is stale while the start pulse is out
                        if (col_done && !col_start)
                            state <= ST_ISSUE;
                    end
                    ST_ISSUE: begin
                        drv_req <= '{valid: 1'b1, op: op_q, len: col_bits, data: col_data};
                        if (op_q == OP_SEQ)
                            remain_q <= remain_q - seqlen_t'(col_bits);
                        state <= ST_WAIT;
                    end
                    ST_WAIT: begin
                        if (drv_ack) begin
                            if (op_q == OP_SEQ && remain_q != '0) begin
                                col_bits  <= chunk(remain_q);
                                col_start <= 1'b1;
                                state     <= ST_COLLECT;
                            end else begin
                                ram_wr.addr <= '0;
                                ram_wr.data <= (op_q == OP_PINS) ? drv_rdata : 8'h00;
                                state       <= ST_REPLY;
                            end
                        end
                    end
                    ST_REPLY: begin
                        ram_wr.en  <= 1'b1;
                        packet_len <= ram_addr_t'(1);
                        done[(op_q == OP_PINS) ? `SWJ_CMD_PINS : `SWJ_CMD_SEQ] <= 1'b1;
                        state <= ST_DONE;
                    end
                    default: ;  // hold until start drops
                endcase
            end
        end
    end

endmodule

// File: src/swj_top.sv
`timescale 1ns/1ps
`include "swj_cfg.svh"

module swj_top
    import swj_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  reg_bus_t  bus,
    output word_t     rdata,
    input  cmd_vec_t  start,
    output cmd_vec_t  done,
    input  logic      in_valid,
    input  byte_t     in_data,
    output logic      in_ready,
    output ram_wr_t   ram_wr,
    output ram_addr_t packet_len,
    input  pin_in_t   pins_in,
    output logic      swclk_o,
    output logic      swdio_o,
    output logic      swdio_oe,
    output logic      tdi_o,
    output logic      trst_o,
    output logic      srst_o,
    output logic      swd_mode
);

    clkdiv_t  clkdiv;
    logic     tick;
    logic     timer_run;
    logic     col_start;
    bitlen_t  col_bits;
    logic     col_done;
    payload_t col_data;
    logic     col_ready;
    drv_req_t drv_req;
    logic     drv_busy;
    logic     drv_ack;
    byte_t    drv_rdata;

    // length byte goes to the fsm, col_bits stays zero while it is idle
    assign in_ready = col_ready || (start[`SWJ_CMD_SEQ] && col_bits == '0);

    swj_reg_bank swj_reg_bank_i (
        .clk      (clk),
        .resetn   (resetn),
        .bus      (bus),
        .rdata    (rdata),
        .swd_mode (swd_mode),
        .clkdiv   (clkdiv)
    );

    swj_clk_timer swj_clk_timer_i (
        .clk    (clk),
        .resetn (resetn),
        .run    (timer_run),
        .clkdiv (clkdiv),
        .tick   (tick)
    );

    swj_byte_collector swj_byte_collector_i (
        .clk      (clk),
        .resetn   (resetn),
        .start    (col_start),
        .bits     (col_bits),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_ready (col_ready),
        .done     (col_done),
        .data     (col_data)
    );

    swj_pin_driver swj_pin_driver_i (
        .clk       (clk),
        .resetn    (resetn),
        .req       (drv_req),
        .tick      (tick),
        .timer_run (timer_run),
        .busy      (drv_busy),
        .ack       (drv_ack),
        .rdata     (drv_rdata),
        .pins_in   (pins_in),
        .swclk_o   (swclk_o),
        .swdio_o   (swdio_o),
        .swdio_oe  (swdio_oe),
        .tdi_o     (tdi_o),
        .trst_o    (trst_o),
        .srst_o    (srst_o)
    );

    swj_cmd_fsm swj_cmd_fsm_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .done       (done),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .col_start  (col_start),
        .col_bits   (col_bits),
        .col_done   (col_done),
        .col_data   (col_data),
        .drv_req    (drv_req),
        .drv_ack    (drv_ack),
        .drv_rdata  (drv_rdata),
        .ram_wr     (ram_wr),
        .packet_len (packet_len)
    );

endmodule

// File: bench/swj_top_chk.sv
`timescale 1ns/1ps
`include "swj_cfg.svh"

module swj_top_chk
    import swj_pkg::*;
(
    input logic     clk,
    input logic     resetn,
    input cmd_vec_t start,
    input cmd_vec_t done,
    input logic     in_ready,
    input logic     ram_wr_en,
    input logic     drv_busy,
    input logic     swclk_o,
    input logic     swdio_oe,
    input logic     trst_o,
    input logic     srst_o
);

    int n_fail = 0;

    a_done_seq: assert property (@(posedge clk) disable iff (!resetn)
        $rose(done[`SWJ_CMD_SEQ]) |-> start[`SWJ_CMD_SEQ])
        else begin
            $error("sequence done rose without its start bit");
            n_fail++;
        end

    a_done_pins: assert property (@(posedge clk) disable iff (!resetn)
        $rose(done[`SWJ_CMD_PINS]) |-> start[`SWJ_CMD_PINS])
        else begin
            $error("pins done rose without its start bit");
            n_fail++;
        end

    a_wr_start: assert property (@(posedge clk) disable iff (!resetn)
        ram_wr_en |-> start != '0)
        else begin
            $error("response write with no command running");
            n_fail++;
        end

    // oe only while a sequence command is still shifting
    a_oe_seq: assert property (@(posedge clk) disable iff (!resetn)
        swdio_oe |-> (start[`SWJ_CMD_SEQ] && !done[`SWJ_CMD_SEQ]))
        else begin
            $error("swdio output enabled outside a sequence");
            n_fail++;
        end

    a_reset: assert property (@(posedge clk)
        $rose(resetn) |-> (done == '0 && !in_ready && !ram_wr_en && !swdio_oe
                           && !drv_busy && !swclk_o && trst_o && srst_o))
        else begin
            $error("outputs not in reset state when reset released");
            n_fail++;
        end

endmodule

bind swj_top swj_top_chk swj_top_chk_i (
    .clk       (clk),
    .resetn    (resetn),
    .start     (start),
    .done      (done),
    .in_ready  (in_ready),
    .ram_wr_en (ram_wr.en),
    .drv_busy  (drv_busy),
    .swclk_o   (swclk_o),
    .swdio_oe  (swdio_oe),
    .trst_o    (trst_o),
    .srst_o    (srst_o)
);

// File: bench/swj_top_tb.sv
`timescale 1ns/1ps
`include "swj_cfg.svh"

module swj_top_tb
    import swj_pkg::*;
();

    localparam int tmo_cycles = 4000;

    logic         clk;
    logic         resetn;
    reg_bus_t     bus;
    word_t        rdata;
    cmd_vec_t     start;
    cmd_vec_t     done;
    logic         in_valid;
    byte_t        in_data;
    logic         in_ready;
    ram_wr_t      ram_wr;
    ram_addr_t    packet_len;
    pin_in_t      pins_in;
    logic         swclk_o;
    logic         swdio_o;
    logic         swdio_oe;
    logic         tdi_o;
    logic         trst_o;
    logic         srst_o;
    logic         swd_mode;

    logic [31:0]  tdata [0:255];
    byte_t        stream_q[$];
    int           n_err;
    int           n_acc;     // bytes taken by the dut
    int           n_edges;
    int           n_wr;
    ram_wr_t      last_wr;
    logic         swclk_prev;
    logic [255:0] seen_bits;
    logic [31:0]  lcg_state;
    logic         swclk_m;   // expected swclk and tdi levels
    logic         tdi_m;

    swj_top swj_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic drive_stream();
        in_valid = stream_q.size() > 0;
        in_data  = (stream_q.size() > 0) ? stream_q[0] : 8'h00;
    endtask

    // sample on the rising edge, drive on the falling one
    task automatic run_cycle();
        @(posedge clk);
        if (in_valid && in_ready) begin
            stream_q.delete(0);
            n_acc++;
        end
        if (swclk_o && !swclk_prev) begin
            if (n_edges < 256)
                seen_bits[n_edges] = swdio_o;
            n_edges++;
        end
        swclk_prev = swclk_o;
        if (ram_wr.en) begin
            n_wr++;
            last_wr = ram_wr;
        end
        @(negedge clk);
        drive_stream();
    endtask

    task automatic push_extra(input int n);
        for (int i = 0; i < n; i++)
            stream_q.push_back(8'hE0 + 8'(i));
    endtask

    task automatic await_done(input int b);
        int cyc;
        cyc = 0;
        while (!done[b] && cyc < tmo_cycles) begin
            run_cycle();
            cyc++;
        end
        if (!done[b]) begin
            $display("timeout while waiting for done[%0d]", b);
            n_err++;
        end
        run_cycle();  // reply write lands here
        start = '0;
        cyc = 0;
        while (done != '0 && cyc < tmo_cycles) begin
            run_cycle();
            cyc++;
        end
        if (done != '0) begin
            $display("timeout while waiting for done to clear");
            n_err++;
        end
        stream_q.delete();
        drive_stream();
    endtask

    task automatic check_reply(input byte_t exp, input int exp_acc);
        if (n_acc != exp_acc) begin
            $display("mismatch accepted bytes: got %h expected %h", n_acc, exp_acc);
            n_err++;
        end
        if (n_wr != 1) begin
            $display("expected one response write but saw %0d", n_wr);
            n_err++;
        end else if (last_wr.addr !== '0 || last_wr.data !== exp) begin
            $display("mismatch ram_wr: got %h/%h expected 000/%h",
                     last_wr.addr, last_wr.data, exp);
            n_err++;
        end
        if (packet_len !== ram_addr_t'(1)) begin
            $display("mismatch packet_len: got %h expected 001", packet_len);
            n_err++;
        end
    endtask

    task automatic reg_write(input logic [11:0] addr, input word_t data,
                             input logic [3:0] strb);
        bus = '{write_en: 1'b1, read_en: 1'b0, addr: addr, wdata: data, byte_strobe: strb};
        @(posedge clk);
        @(negedge clk);
        bus.write_en = 1'b0;
    endtask

    task automatic reg_check(input logic [11:0] addr, input word_t exp);
        word_t got;
        bus.read_en = 1'b1;
        bus.addr    = addr;
        @(posedge clk);
        got = rdata;
        @(negedge clk);
        bus.read_en = 1'b0;
        if (got !== exp) begin
            $display("mismatch rdata at %h: got %h expected %h", addr, got, exp);
            n_err++;
        end
        if (addr == `SWJ_CR_OFS && swd_mode !== exp[0]) begin
            $display("mismatch swd_mode: got %h expected %h", swd_mode, exp[0]);
            n_err++;
        end
    endtask

    task automatic run_sequence(inout int p);
        int           bits;
        int           nbytes;
        int           extra;
        byte_t        reply;
        logic [255:0] exp_bits;
        logic [255:0] mask;
        bits     = (tdata[p+1][7:0] == 8'd0) ? 256 : int'(tdata[p+1][7:0]);
        nbytes   = (bits + 7) / 8;
        extra    = tdata[p+2];
        reply    = tdata[p+3][7:0];
        exp_bits = '0;
        for (int i = 0; i < nbytes; i++)
            exp_bits[i*8 +: 8] = tdata[p + 4 + i/4][(i%4)*8 +: 8];
        mask = {256{1'b1}} >> (256 - bits);
        n_acc     = 0;
        n_edges   = 0;
        n_wr      = 0;
        seen_bits = '0;
        stream_q.push_back(tdata[p+1][7:0]);  // length byte
        for (int i = 0; i < nbytes; i++)
            stream_q.push_back(exp_bits[i*8 +: 8]);
        push_extra(extra);
        start[`SWJ_CMD_SEQ] = 1'b1;
        drive_stream();
        await_done(`SWJ_CMD_SEQ);
        swclk_m = 1'b0;  // sequence ends on a low phase
        if (n_edges != bits) begin
            $display("mismatch swclk_o rising edges: got %h expected %h", n_edges, bits);
            n_err++;
        end
        if ((seen_bits & mask) !== (exp_bits & mask)) begin
            $display("mismatch swdio_o bits: got %h expected %h",
                     seen_bits & mask, exp_bits & mask);
            n_err++;
        end
        check_reply(reply, 1 + nbytes);
        p = p + 4 + (nbytes + 3) / 4;
    endtask

    task automatic run_pins(input int p);
        byte_t       value;
        byte_t       sel;
        byte_t       reply;
        byte_t       outs;
        word_t       wait_w;
        int          extra;
        logic [31:0] rnd;
        value  = tdata[p+1][7:0];
        sel    = tdata[p+2][7:0];
        wait_w = tdata[p+3];
        extra  = tdata[p+4];
        rnd    = lcg_next();
        pins_in = rnd[19:16];
        if (sel[0])
            swclk_m = value[0];
        if (sel[2])
            tdi_m = value[2];
        // swclk out, swdio in, tdi out, tdo in, ntrst in, nreset in
        reply    = '0;
        reply[0] = swclk_m;
        reply[1] = pins_in.swdio;
        reply[2] = tdi_m;
        reply[3] = pins_in.tdo;
        reply[5] = pins_in.trst_n;
        reply[7] = pins_in.srst_n;
        n_acc = 0;
        n_wr  = 0;
        stream_q.push_back(value);
        stream_q.push_back(sel);
        for (int i = 0; i < 4; i++)
            stream_q.push_back(wait_w[i*8 +: 8]);
        push_extra(extra);
        start[`SWJ_CMD_PINS] = 1'b1;
        drive_stream();
        await_done(`SWJ_CMD_PINS);
        outs = {srst_o, 1'b0, trst_o, 2'b00, tdi_o, swdio_o, swclk_o};
        if ((outs & sel & 8'hA7) !== (value & sel & 8'hA7)) begin
            $display("mismatch pin outputs: got %h expected %h",
                     outs & sel & 8'hA7, value & sel & 8'hA7);
            n_err++;
        end
        check_reply(reply, 6);
    endtask

    initial begin
        int p;
        int n_assert;
        resetn     = 1'b0;
        bus        = '0;
        start      = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        pins_in    = '0;
        n_err      = 0;
        n_acc      = 0;
        n_edges    = 0;
        n_wr       = 0;
        last_wr    = '0;
        swclk_prev = 1'b0;
        seen_bits  = '0;
        lcg_state  = 32'd86;
        swclk_m    = 1'b0;
        tdi_m      = 1'b0;
        $readmemh("bench/swj_testdata.txt", tdata);
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        if ($isunknown(tdata[0])) begin
            $display("test data file is missing or empty");
            n_err++;
        end
        p = 0;
        while (p < 240 && tdata[p] != 32'd0) begin
            case (tdata[p])
                32'd1: begin
                    reg_write(tdata[p+1][11:0], tdata[p+2], tdata[p+3][3:0]);
                    p = p + 4;
                end
                32'd2: begin
                    reg_check(tdata[p+1][11:0], tdata[p+2]);
                    p = p + 3;
                end
                32'd3: run_sequence(p);
                32'd4: begin
                    run_pins(p);
                    p = p + 5;
                end
                default: begin
                    $display("unknown record type %h at word %0d", tdata[p], p);
                    n_err++;
                    p = 240;
                end
            endcase
        end

        n_assert = swj_top_i.swj_top_chk_i.n_fail;
        $display("errors: %0d check, %0d assertion", n_err, n_assert);
        if (n_err == 0 && n_assert == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/swj_testdata.txt
// one record per line, hex: 1 addr wdata strobe | 2 addr expected_rdata
// 3 len extra reply payload_words (byte 0 in bits 7:0) | 4 value select wait extra | 0 end
1 000 12345679 1
2 000 00000079
1 004 ABCD0002 3
1 004 55667788 8
2 004 55000002
1 00C FFFFFFFF F
1 000 DEADBEEE 6
2 000 00ADBE79
2 004 55000002
2 008 00000000
2 00C 00000000
2 100 00000000
3 0D 3 00 00001A5B
4 A5 A7 00000010 2
3 00 2 00
  8F3A61C2 47D90B5E E2146A9D 5C0B7F31
  9A6E24D8 31C5F0A7 D48B1E63 6F20C9B5
4 00 A1 00000000 5
3 28 4 00 A1B2C3D4 000000E5
4 FF 06 0000FF00 1
1 000 00000000 1
2 000 00ADBE00
0

// File: src.f
+incdir+src
src/swj_pkg.sv
src/swj_reg_bank.sv
src/swj_clk_timer.sv
src/swj_byte_collector.sv
src/swj_pin_driver.sv
src/swj_cmd_fsm.sv
src/swj_top.sv
bench/swj_top_chk.sv
bench/swj_top_tb.sv

// File: Bender.yml
package:
  name: swj_cmd_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/swj_pkg.sv
      - src/swj_reg_bank.sv
      - src/swj_clk_timer.sv
      - src/swj_byte_collector.sv
      - src/swj_pin_driver.sv
      - src/swj_cmd_fsm.sv
      - src/swj_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/swj_top_chk.sv
      - bench/swj_top_tb.sv
